// File: design/spr_pkg.sv
package spr_pkg;

  // word index on the bus, the byte address is the index times four.
  typedef enum logic [4:0] {
    idx_vr       = 5'd0,
    idx_vr2      = 5'd1,
    idx_avr      = 5'd2,
    idx_upr      = 5'd3,
    idx_cpucfgr  = 5'd4,
    idx_dccfgr   = 5'd5,
    idx_iccfgr   = 5'd6,
    idx_dmmucfgr = 5'd7,
    idx_immucfgr = 5'd8,
    idx_dcfgr    = 5'd9,
    idx_pccfgr   = 5'd10,
    idx_fpcsr    = 5'd11,
    // tick timer group.
    idx_ttmr     = 5'd16,
    idx_ttcr     = 5'd17
  } spr_idx_e;

  // ttmr mode field, bits 31:30.
  typedef enum logic [1:0] {
    mode_disabled   = 2'd0,
    mode_restart    = 2'd1,
    mode_oneshot    = 2'd2,
    mode_continuous = 2'd3
  } timer_mode_e;

  typedef enum logic [1:0] {
    st_idle,
    st_write_resp,
    st_read_resp
  } axil_state_e;

  typedef enum logic [1:0] {
    resp_okay   = 2'd0,
    resp_slverr = 2'd2
  } axil_resp_e;

  // ttmr fields.
  localparam int ttmr_ie       = 29;
  localparam int ttmr_ip       = 28;
  localparam int ttmr_tp_width = 28;

  // implementation id and version, reported in vr and vr2.
  localparam logic [7:0] cpuid         = 8'h12;
  localparam logic [7:0] version_major = 8'd5;
  localparam logic [7:0] version_minor = 8'd1;
  localparam logic [7:0] vr_ver        = 8'h10;

  // field positions of the configuration registers.
  localparam int vr_ver_lsb     = 24;
  localparam int vr_uvrp        = 6;
  localparam int vr2_cpuid_lsb  = 24;
  localparam int avr_maj_lsb    = 24;
  localparam int upr_up         = 0;
  localparam int upr_dcp        = 1;
  localparam int upr_icp        = 2;
  localparam int upr_picp       = 8;
  localparam int upr_ttp        = 10;
  localparam int cpucfgr_ob32s  = 5;
  localparam int cpucfgr_nd     = 10;
  localparam int cpucfgr_avrp   = 11;
  localparam int cpucfgr_evbarp = 12;
  localparam int cpucfgr_isrp   = 13;
  // shared by dccfgr and iccfgr.
  localparam int cfgr_ncw_lsb   = 0;
  localparam int cfgr_ncs_lsb   = 3;
  localparam int cfgr_cbs       = 7;
  localparam int cfgr_cbiri     = 10;
  // data cache only.
  localparam int dccfgr_cbfri   = 13;

endpackage

// File: design/spr_bus_if.sv
interface spr_bus_if;

  // one register access, valid for a single cycle.
  logic              valid;
  logic              we;
  spr_pkg::spr_idx_e idx;
  logic [31:0]       wdata;

  // result, returned in the same cycle as valid.
  logic [31:0]       rdata;
  logic              err;

  modport ctrl (
    output valid,
    output we,
    output idx,
    output wdata,
    input  rdata,
    input  err
  );

  modport regs (
    input  valid,
    input  we,
    input  idx,
    input  wdata,
    output rdata,
    output err
  );

endinterface

// File: design/spr_cfgrs.sv
module spr_cfgrs #(
  parameter     feature_datacache        = "ENABLED",
  parameter int option_dcache_set_width  = 9,
  parameter int option_dcache_ways       = 2,
  parameter     feature_instructioncache = "ENABLED",
  parameter int option_icache_set_width  = 8,
  parameter int option_icache_ways       = 1,
  parameter     feature_pic              = "ENABLED",
  parameter     feature_timer            = "ENABLED",
  parameter     feature_delayslot        = "NONE",
  parameter     feature_evbar            = "ENABLED"
) (
  output logic [11:0][31:0] cfg_words
);

  // both caches use 32 byte lines.
  localparam int cache_block_width = 5;
  localparam bit dc_present = (feature_datacache != "NONE");
  localparam bit ic_present = (feature_instructioncache != "NONE");

  logic [31:0] vr;
  logic [31:0] vr2;
  logic [31:0] avr;
  logic [31:0] upr;
  logic [31:0] cpucfgr;
  logic [31:0] dccfgr;
  logic [31:0] iccfgr;

  // number of ways as log2, unsupported counts report one way.
  function automatic logic [2:0] ways_code(input int ways);
    case (ways)
      2:       ways_code = 3'd1;
      4:       ways_code = 3'd2;
      8:       ways_code = 3'd3;
      16:      ways_code = 3'd4;
      32:      ways_code = 3'd5;
      default: ways_code = 3'd0;
    endcase
  endfunction

  always_comb begin
    vr = '0;
    vr[spr_pkg::vr_ver_lsb +: 8] = spr_pkg::vr_ver;
    // vr2 holds the full version.
    vr[spr_pkg::vr_uvrp] = 1'b1;
    vr2 = '0;
    vr2[spr_pkg::vr2_cpuid_lsb +: 8] = spr_pkg::cpuid;
    vr2[23:0] = {spr_pkg::version_major, spr_pkg::version_minor, 8'd0};
    // architecture version 1.0 rev 0.
    avr = '0;
    avr[spr_pkg::avr_maj_lsb +: 8] = 8'd1;
    upr = '0;
    upr[spr_pkg::upr_up]   = 1'b1;
    upr[spr_pkg::upr_dcp]  = dc_present;
    upr[spr_pkg::upr_icp]  = ic_present;
    upr[spr_pkg::upr_picp] = (feature_pic != "NONE");
    upr[spr_pkg::upr_ttp]  = (feature_timer != "NONE");
    cpucfgr = '0;
    cpucfgr[spr_pkg::cpucfgr_ob32s]  = 1'b1;
    cpucfgr[spr_pkg::cpucfgr_nd]     = (feature_delayslot == "NONE");
    cpucfgr[spr_pkg::cpucfgr_avrp]   = 1'b1;
    cpucfgr[spr_pkg::cpucfgr_evbarp] = (feature_evbar != "NONE");
    cpucfgr[spr_pkg::cpucfgr_isrp]   = 1'b1;
  end

  // cache fields read as zero when the cache is absent.
  always_comb begin
    dccfgr = '0;
    iccfgr = '0;
    if (dc_present) begin
      dccfgr[spr_pkg::cfgr_ncw_lsb +: 3] = ways_code(option_dcache_ways);
      dccfgr[spr_pkg::cfgr_ncs_lsb +: 4] = 4'(option_dcache_set_width);
      dccfgr[spr_pkg::cfgr_cbs]          = (cache_block_width == 5);
      dccfgr[spr_pkg::cfgr_cbiri]        = 1'b1;
      dccfgr[spr_pkg::dccfgr_cbfri]      = 1'b1;
    end
    if (ic_present) begin
      iccfgr[spr_pkg::cfgr_ncw_lsb +: 3] = ways_code(option_icache_ways);
      iccfgr[spr_pkg::cfgr_ncs_lsb +: 4] = 4'(option_icache_set_width);
      iccfgr[spr_pkg::cfgr_cbs]          = (cache_block_width == 5);
      iccfgr[spr_pkg::cfgr_cbiri]        = 1'b1;
    end
  end

  // mmu, debug, perf counter and fpu words stay zero.
  always_comb begin
    cfg_words = '0;
    cfg_words[spr_pkg::idx_vr]      = vr;
    cfg_words[spr_pkg::idx_vr2]     = vr2;
    cfg_words[spr_pkg::idx_avr]     = avr;
    cfg_words[spr_pkg::idx_upr]     = upr;
    cfg_words[spr_pkg::idx_cpucfgr] = cpucfgr;
    cfg_words[spr_pkg::idx_dccfgr]  = dccfgr;
    cfg_words[spr_pkg::idx_iccfgr]  = iccfgr;
  end

endmodule

// File: design/spr_tick_timer.sv
module spr_tick_timer (
  input  logic        clk,
  input  logic        reset,
  input  logic        ttmr_we,
  input  logic        ttcr_we,
  input  logic [31:0] wr_data,
  output logic [31:0] ttmr,
  output logic [31:0] ttcr,
  output logic        tick_irq
);

  spr_pkg::timer_mode_e mode;
  logic ie;
  logic ip;
  logic [spr_pkg::ttmr_tp_width-1:0] tp;
  logic [31:0] count;
  logic match;
  logic match_q;
  logic running;

  // only the low 28 bits take part in the compare.
  assign match = (count[spr_pkg::ttmr_tp_width-1:0] == tp) &&
                 (mode != spr_pkg::mode_disabled);
  // oneshot freezes the count once it hits tp.
  assign running = (mode != spr_pkg::mode_disabled) &&
                   !((mode == spr_pkg::mode_oneshot) && match);

  assign ttmr = {mode, ie, ip, tp};
  assign ttcr = count;

  // mode register.
  always_ff @(posedge clk) begin
    if (reset) begin
      mode    <= spr_pkg::mode_disabled;
      ie      <= 1'b0;
      ip      <= 1'b0;
      tp      <= '0;
      match_q <= 1'b0;
    end else begin
      match_q <= match;
      if (ttmr_we) begin
        mode <= spr_pkg::timer_mode_e'(wr_data[31:30]);
        ie   <= wr_data[spr_pkg::ttmr_ie];
        ip   <= wr_data[spr_pkg::ttmr_ip];
        tp   <= wr_data[spr_pkg::ttmr_tp_width-1:0];
      end else if (match && !match_q) begin
        // set on the first cycle of a match, so a held oneshot match
        // does not pend again after software clears ip.
        ip <= 1'b1;
      end
    end
  end

  // count register.
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (ttcr_we) begin
      count <= wr_data;
    end else if (match && (mode == spr_pkg::mode_restart)) begin
      count <= '0;
    end else if (running) begin
      count <= count + 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tick_irq <= 1'b0;
    end else begin
      tick_irq <= ie && ip;
    end
  end

  // a disabled timer keeps its count.
  assert property (@(posedge clk) disable iff (reset)
    (mode == spr_pkg::mode_disabled) && !ttcr_we |=> $stable(count));

endmodule

// File: design/spr_axil_ctrl.sv
module spr_axil_ctrl (
  input  logic                clk,
  input  logic                reset,
  input  logic                awvalid,
  output logic                awready,
  input  logic [6:0]          awaddr,
  input  logic                wvalid,
  output logic                wready,
  input  logic [31:0]         wdata,
  output logic                bvalid,
  input  logic                bready,
  output spr_pkg::axil_resp_e bresp,
  input  logic                arvalid,
  output logic                arready,
  input  logic [6:0]          araddr,
  output logic                rvalid,
  input  logic                rready,
  output logic [31:0]         rdata,
  output spr_pkg::axil_resp_e rresp,
  spr_bus_if.ctrl             bus
);

  spr_pkg::axil_state_e state;
  logic wr_accept;
  logic rd_accept;

  // address and data of a write are taken together.
  assign wr_accept = (state == spr_pkg::st_idle) && awvalid && wvalid;
  // writes win over a read offered in the same cycle.
  assign rd_accept = (state == spr_pkg::st_idle) && arvalid && !(awvalid && wvalid);

  assign awready = wr_accept;
  assign wready  = wr_accept;
  assign arready = rd_accept;

  // the internal access lasts exactly the accepting cycle.
  assign bus.valid = wr_accept || rd_accept;
  assign bus.we    = wr_accept;
  // byte address to word index, low two bits dropped.
  assign bus.idx   = wr_accept ? spr_pkg::spr_idx_e'(awaddr[6:2]) :
                                 spr_pkg::spr_idx_e'(araddr[6:2]);
  assign bus.wdata = wdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= spr_pkg::st_idle;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      case (state)
        spr_pkg::st_idle: begin
          if (wr_accept) begin
            state  <= spr_pkg::st_write_resp;
            bvalid <= 1'b1;
          end else if (rd_accept) begin
            state  <= spr_pkg::st_read_resp;
            rvalid <= 1'b1;
          end
        end
        spr_pkg::st_write_resp: begin
          if (bready) begin
            state  <= spr_pkg::st_idle;
            bvalid <= 1'b0;
          end
        end
        spr_pkg::st_read_resp: begin
          if (rready) begin
            state  <= spr_pkg::st_idle;
            rvalid <= 1'b0;
          end
        end
        default: begin
          state <= spr_pkg::st_idle;
        end
      endcase
    end
  end

  // response payload, captured at the accepting edge.
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      bresp <= bus.err ? spr_pkg::resp_slverr : spr_pkg::resp_okay;
    end
    if (rd_accept) begin
      rdata <= bus.rdata;
      rresp <= bus.err ? spr_pkg::resp_slverr : spr_pkg::resp_okay;
    end
  end

  // one transaction in flight.
  assert property (@(posedge clk) disable iff (reset) !(bvalid && rvalid));

  // write response is held until taken.
  assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid);

endmodule

// File: design/spr_decode.sv
module spr_decode #(
  parameter feature_timer = "ENABLED"
) (
  spr_bus_if.regs           bus,
  output logic              ttmr_we,
  output logic              ttcr_we,
  output logic [31:0]       wr_data,
  input  logic [31:0]       ttmr,
  input  logic [31:0]       ttcr,
  input  logic [11:0][31:0] cfg_words
);

  localparam bit timer_present = (feature_timer != "NONE");

  // read data and error for the index on the bus.
  always_comb begin
    bus.rdata = '0;
    bus.err   = 1'b0;
    case (bus.idx)
      spr_pkg::idx_ttmr: begin
        bus.rdata = timer_present ? ttmr : '0;
        bus.err   = !timer_present;
      end
      spr_pkg::idx_ttcr: begin
        bus.rdata = timer_present ? ttcr : '0;
        bus.err   = !timer_present;
      end
      default: begin
        if (bus.idx <= spr_pkg::idx_fpcsr) begin
          // configuration words are read only.
          bus.rdata = cfg_words[bus.idx];
          bus.err   = bus.we;
        end else begin
          bus.err = 1'b1;
        end
      end
    endcase
  end

  // timer writes go through only when the access is taken and legal.
  assign ttmr_we = bus.valid && bus.we && timer_present && (bus.idx == spr_pkg::idx_ttmr);
  assign ttcr_we = bus.valid && bus.we && timer_present && (bus.idx == spr_pkg::idx_ttcr);
  assign wr_data = bus.wdata;

endmodule

// File: design/spr_unit_top.sv
module spr_unit_top #(
  parameter     feature_datacache        = "ENABLED",
  parameter int option_dcache_set_width  = 9,
  parameter int option_dcache_ways       = 2,
  parameter     feature_instructioncache = "ENABLED",
  parameter int option_icache_set_width  = 8,
  parameter int option_icache_ways       = 1,
  parameter     feature_pic              = "ENABLED",
  parameter     feature_timer            = "ENABLED",
  parameter     feature_delayslot        = "NONE",
  parameter     feature_evbar            = "ENABLED"
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        awvalid,
  output logic        awready,
  input  logic [6:0]  awaddr,
  input  logic        wvalid,
  output logic        wready,
  input  logic [31:0] wdata,
  output logic        bvalid,
  input  logic        bready,
  output logic [1:0]  bresp,
  input  logic        arvalid,
  output logic        arready,
  input  logic [6:0]  araddr,
  output logic        rvalid,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        tick_irq
);

  spr_bus_if bus ();

  logic              ttmr_we;
  logic              ttcr_we;
  logic [31:0]       wr_data;
  logic [31:0]       ttmr;
  logic [31:0]       ttcr;
  logic [11:0][31:0] cfg_words;

  spr_axil_ctrl u_ctrl (
    .clk     (clk),
    .reset   (reset),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .bus     (bus.ctrl)
  );

  spr_decode #(
    .feature_timer (feature_timer)
  ) u_decode (
    .bus       (bus.regs),
    .ttmr_we   (ttmr_we),
    .ttcr_we   (ttcr_we),
    .wr_data   (wr_data),
    .ttmr      (ttmr),
    .ttcr      (ttcr),
    .cfg_words (cfg_words)
  );

  spr_cfgrs #(
    .feature_datacache        (feature_datacache),
    .option_dcache_set_width  (option_dcache_set_width),
    .option_dcache_ways       (option_dcache_ways),
    .feature_instructioncache (feature_instructioncache),
    .option_icache_set_width  (option_icache_set_width),
    .option_icache_ways       (option_icache_ways),
    .feature_pic              (feature_pic),
    .feature_timer            (feature_timer),
    .feature_delayslot        (feature_delayslot),
    .feature_evbar            (feature_evbar)
  ) u_cfgrs (
    .cfg_words (cfg_words)
  );

  spr_tick_timer u_timer (
    .clk      (clk),
    .reset    (reset),
    .ttmr_we  (ttmr_we),
    .ttcr_we  (ttcr_we),
    .wr_data  (wr_data),
    .ttmr     (ttmr),
    .ttcr     (ttcr),
    .tick_irq (tick_irq)
  );

endmodule

// File: testbench/tb_spr_unit.sv
module tb_spr_unit;

  timeunit 1ns;
  timeprecision 1ps;

  // configuration of the DUT, also used for the expected register values.
  localparam int dc_ways      = 2;
  localparam int dc_set_width = 9;
  localparam int ic_ways      = 1;
  localparam int ic_set_width = 8;

  typedef enum logic {
    op_read,
    op_write
  } op_e;

  // one row of the stimulus table.
  typedef struct packed {
    op_e                 op;
    spr_pkg::spr_idx_e   idx;
    logic [31:0]         wdata;
    logic [31:0]         exp_data;
    spr_pkg::axil_resp_e exp_resp;
  } entry_t;

  logic        clk = 1'b0;
  logic        reset;
  logic        awvalid;
  logic        awready;
  logic [6:0]  awaddr;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        arvalid;
  logic        arready;
  logic [6:0]  araddr;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        tick_irq;

  entry_t table_q[$];

  spr_unit_top #(
    .feature_datacache        ("ENABLED"),
    .option_dcache_set_width  (dc_set_width),
    .option_dcache_ways       (dc_ways),
    .feature_instructioncache ("ENABLED"),
    .option_icache_set_width  (ic_set_width),
    .option_icache_ways       (ic_ways),
    .feature_pic              ("ENABLED"),
    .feature_timer            ("ENABLED"),
    .feature_delayslot        ("NONE"),
    .feature_evbar            ("ENABLED")
  ) DUT (
    .clk      (clk),
    .reset    (reset),
    .awvalid  (awvalid),
    .awready  (awready),
    .awaddr   (awaddr),
    .wvalid   (wvalid),
    .wready   (wready),
    .wdata    (wdata),
    .bvalid   (bvalid),
    .bready   (bready),
    .bresp    (bresp),
    .arvalid  (arvalid),
    .arready  (arready),
    .araddr   (araddr),
    .rvalid   (rvalid),
    .rready   (rready),
    .rdata    (rdata),
    .rresp    (rresp),
    .tick_irq (tick_irq)
  );

  // 8 ns period.
  always #4 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input spr_pkg::axil_resp_e exp,
                            input spr_pkg::axil_resp_e act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  // log2 of the way count, counts that are not a power of two up to 32 give 0.
  function automatic logic [2:0] ways_log2(input int ways);
    int n;
    n = 0;
    while ((1 << n) < ways) begin
      n++;
    end
    if (((1 << n) != ways) || (n > 5)) begin
      return 3'd0;
    end
    return 3'(n);
  endfunction

  // register contents from the or1k field layout and the DUT parameters.
  function automatic logic [31:0] expected_cfg(input spr_pkg::spr_idx_e idx);
    logic [31:0] w;
    w = '0;
    case (idx)
      spr_pkg::idx_vr: begin
        // version code on top, updated version present in bit 6.
        w[31:24] = spr_pkg::vr_ver;
        w[6]     = 1'b1;
      end
      spr_pkg::idx_vr2: begin
        w = {spr_pkg::cpuid, spr_pkg::version_major, spr_pkg::version_minor, 8'h00};
      end
      spr_pkg::idx_avr: begin
        w[31:24] = 8'd1;
      end
      spr_pkg::idx_upr: begin
        // present, dcache, icache, pic and tick timer.
        w[0]  = 1'b1;
        w[1]  = 1'b1;
        w[2]  = 1'b1;
        w[8]  = 1'b1;
        w[10] = 1'b1;
      end
      spr_pkg::idx_cpucfgr: begin
        // ob32s, no delay slot, avr, evbar and isr present.
        w[5]  = 1'b1;
        w[10] = 1'b1;
        w[11] = 1'b1;
        w[12] = 1'b1;
        w[13] = 1'b1;
      end
      spr_pkg::idx_dccfgr: begin
        w[2:0] = ways_log2(dc_ways);
        w[6:3] = 4'(dc_set_width);
        // 32 byte blocks, invalidate and flush registers.
        w[7]   = 1'b1;
        w[10]  = 1'b1;
        w[13]  = 1'b1;
      end
      spr_pkg::idx_iccfgr: begin
        w[2:0] = ways_log2(ic_ways);
        w[6:3] = 4'(ic_set_width);
        w[7]   = 1'b1;
        w[10]  = 1'b1;
      end
      default: begin
        w = '0;
      end
    endcase
    return w;
  endfunction

  function automatic logic [31:0] ttmr_word(input spr_pkg::timer_mode_e mode, input logic ie,
                                            input logic ip, input logic [27:0] tp);
    logic [31:0] w;
    w = {4'b0000, tp};
    w[31:30] = mode;
    w[spr_pkg::ttmr_ie] = ie;
    w[spr_pkg::ttmr_ip] = ip;
    return w;
  endfunction

  function automatic void add_entry(input op_e op, input logic [4:0] idx, input logic [31:0] wd,
                                    input logic [31:0] exp, input spr_pkg::axil_resp_e resp);
    entry_t e;
    e.op       = op;
    e.idx      = spr_pkg::spr_idx_e'(idx);
    e.wdata    = wd;
    e.exp_data = exp;
    e.exp_resp = resp;
    table_q.push_back(e);
  endfunction

  // write with both channels offered together, then a random bready delay.
  task automatic axil_write(input spr_pkg::spr_idx_e idx, input logic [31:0] data,
                            output spr_pkg::axil_resp_e resp);
    int waited;
    int delay;
    @(negedge clk);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = {idx, 2'b00};
    wdata   = data;
    // an idle slave takes address and data together in this cycle.
    #2;
    check_flag("awready", 1'b1, awready);
    check_flag("wready", 1'b1, wready);
    waited  = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 8) begin
        abort_run("write was not accepted within 8 cycles");
      end
    end while (!bvalid);
    resp    = spr_pkg::axil_resp_e'(bresp);
    delay   = $urandom_range(3, 0);
    // the same write stays offered and must not be taken while the master stalls.
    repeat (delay) begin
      @(negedge clk);
      check_flag("bvalid", 1'b1, bvalid);
      check_resp("bresp", resp, spr_pkg::axil_resp_e'(bresp));
      check_flag("awready", 1'b0, awready);
      check_flag("wready", 1'b0, wready);
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    @(negedge clk);
    bready = 1'b0;
    check_flag("bvalid", 1'b0, bvalid);
  endtask

  task automatic axil_read(input spr_pkg::spr_idx_e idx, output logic [31:0] data,
                           output spr_pkg::axil_resp_e resp);
    int waited;
    int delay;
    @(negedge clk);
    arvalid = 1'b1;
    araddr  = {idx, 2'b00};
    // with no write offered an idle slave takes the read at once.
    #2;
    check_flag("arready", 1'b1, arready);
    waited  = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 8) begin
        abort_run("read was not accepted within 8 cycles");
      end
    end while (!rvalid);
    data    = rdata;
    resp    = spr_pkg::axil_resp_e'(rresp);
    delay   = $urandom_range(3, 0);
    // the read stays offered and must not be taken while the master stalls.
    repeat (delay) begin
      @(negedge clk);
      check_flag("rvalid", 1'b1, rvalid);
      check_data("rdata", data, rdata);
      check_resp("rresp", resp, spr_pkg::axil_resp_e'(rresp));
      check_flag("arready", 1'b0, arready);
    end
    arvalid = 1'b0;
    rready  = 1'b1;
    @(negedge clk);
    rready = 1'b0;
    check_flag("rvalid", 1'b0, rvalid);
  endtask

  // limit scales with the table length.
  task automatic run_watchdog();
    repeat (table_q.size() * 10 + 200) @(posedge clk);
    abort_run("timeout: the tests did not finish in the expected number of cycles");
  endtask

  initial begin
    spr_pkg::axil_resp_e resp;
    logic [31:0]         data;
    logic [31:0]         first;
    int                  waited;
    void'($urandom(32'h551c_27fa));
    reset   = 1'b1;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;

    // timer idle after reset.
    add_entry(op_read, spr_pkg::idx_ttmr, '0, '0, spr_pkg::resp_okay);
    add_entry(op_read, spr_pkg::idx_ttcr, '0, '0, spr_pkg::resp_okay);
    for (int i = 0; i <= 11; i++) begin
      add_entry(op_read, 5'(i), '0, expected_cfg(spr_pkg::spr_idx_e'(i)), spr_pkg::resp_okay);
    end
    // configuration words are read only.
    add_entry(op_write, spr_pkg::idx_vr, 32'hdead_beef, '0, spr_pkg::resp_slverr);
    add_entry(op_read, spr_pkg::idx_vr, '0, expected_cfg(spr_pkg::idx_vr), spr_pkg::resp_okay);
    add_entry(op_write, spr_pkg::idx_upr, 32'h0000_0000, '0, spr_pkg::resp_slverr);
    add_entry(op_read, spr_pkg::idx_upr, '0, expected_cfg(spr_pkg::idx_upr), spr_pkg::resp_okay);
    // unmapped word indices.
    add_entry(op_read, 5'd12, '0, '0, spr_pkg::resp_slverr);
    add_entry(op_read, 5'd15, '0, '0, spr_pkg::resp_slverr);
    add_entry(op_read, 5'd31, '0, '0, spr_pkg::resp_slverr);
    add_entry(op_write, 5'd20, 32'h1234_5678, '0, spr_pkg::resp_slverr);

    fork
      run_watchdog();
    join_none

    repeat (4) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_flag("awready", 1'b0, awready);
    check_flag("arready", 1'b0, arready);
    check_flag("bvalid", 1'b0, bvalid);
    check_flag("rvalid", 1'b0, rvalid);
    check_flag("tick_irq", 1'b0, tick_irq);

    foreach (table_q[i]) begin
      if (table_q[i].op == op_write) begin
        axil_write(table_q[i].idx, table_q[i].wdata, resp);
        check_resp("bresp", table_q[i].exp_resp, resp);
      end else begin
        axil_read(table_q[i].idx, data, resp);
        check_data("rdata", table_q[i].exp_data, data);
        check_resp("rresp", table_q[i].exp_resp, resp);
      end
    end

    // oneshot with interrupt enabled, the count stops at tp.
    axil_write(spr_pkg::idx_ttcr, 32'd0, resp);
    check_resp("bresp", spr_pkg::resp_okay, resp);
    axil_write(spr_pkg::idx_ttmr, ttmr_word(spr_pkg::mode_oneshot, 1'b1, 1'b0, 28'd20), resp);
    check_resp("bresp", spr_pkg::resp_okay, resp);
    waited = 0;
    while (!tick_irq) begin
      if (waited == 40) begin
        abort_run("tick_irq did not rise within 40 cycles of the TTMR write");
      end
      @(negedge clk);
      waited++;
    end
    repeat (2) begin
      axil_read(spr_pkg::idx_ttcr, data, resp);
      check_data("ttcr", 32'd20, data);
      check_resp("rresp", spr_pkg::resp_okay, resp);
    end
    // clearing ip drops the interrupt.
    axil_write(spr_pkg::idx_ttmr, ttmr_word(spr_pkg::mode_oneshot, 1'b1, 1'b0, 28'd20), resp);
    check_resp("bresp", spr_pkg::resp_okay, resp);
    check_flag("tick_irq", 1'b0, tick_irq);

    // restart mode wraps to zero after tp.
    axil_write(spr_pkg::idx_ttmr, 32'd0, resp);
    check_resp("bresp", spr_pkg::resp_okay, resp);
    axil_write(spr_pkg::idx_ttcr, 32'd0, resp);
    check_resp("bresp", spr_pkg::resp_okay, resp);
    axil_write(spr_pkg::idx_ttmr, ttmr_word(spr_pkg::mode_restart, 1'b0, 1'b0, 28'd15), resp);
    check_resp("bresp", spr_pkg::resp_okay, resp);
    repeat (10) begin
      axil_read(spr_pkg::idx_ttcr, data, resp);
      check_resp("rresp", spr_pkg::resp_okay, resp);
      if (data > 32'd15) begin
        abort_run($sformatf("TTCR read 0x%h in restart mode, above the period of 15", data));
      end
    end

    // continuous mode keeps counting up.
    axil_write(spr_pkg::idx_ttmr, ttmr_word(spr_pkg::mode_continuous, 1'b0, 1'b0, 28'd15), resp);
    check_resp("bresp", spr_pkg::resp_okay, resp);
    axil_read(spr_pkg::idx_ttcr, first, resp);
    check_resp("rresp", spr_pkg::resp_okay, resp);
    axil_read(spr_pkg::idx_ttcr, data, resp);
    check_resp("rresp", spr_pkg::resp_okay, resp);
    if (data <= first) begin
      abort_run($sformatf("TTCR did not increase in continuous mode: 0x%h then 0x%h",
                          first, data));
    end

    $display("All tests passed");
    $finish;
  end

endmodule

// File: project.f
design/spr_pkg.sv
design/spr_bus_if.sv
design/spr_cfgrs.sv
design/spr_tick_timer.sv
design/spr_axil_ctrl.sv
design/spr_decode.sv
design/spr_unit_top.sv
testbench/tb_spr_unit.sv

// File: Bender.yml
package:
  name: spr_unit

sources:
  - design/spr_pkg.sv
  - design/spr_bus_if.sv
  - design/spr_cfgrs.sv
  - design/spr_tick_timer.sv
  - design/spr_axil_ctrl.sv
  - design/spr_decode.sv
  - design/spr_unit_top.sv
  - target: test
    files:
      - testbench/tb_spr_unit.sv
